/* all.f */
+incdir+tb
design/fifo_demo_pkg.sv
design/tick_divider.sv
design/button_strober.sv
design/fifo_control.sv
design/fifo_storage.sv
design/fifo_demo_top.sv
tb/tb_fifo_demo.sv

/* run.sh */
#!/bin/sh
# build and run the fifo demo testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_fifo_demo \
  -f all.f -o sim_fifo_demo

./obj_dir/sim_fifo_demo > sim.log
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run.sh: testbench reported failure"
  exit 1
fi
echo "run.sh: testbench reported no failure"
exit 0

/* tb/tb_fifo_checks.svh */
`ifndef TB_FIFO_CHECKS_SVH
`define TB_FIFO_CHECKS_SVH

// error counts, one per kind of result
int word_errors  = 0;
int flag_errors  = 0;
int level_errors = 0;

// dout against the word the model last popped
task automatic compare_word(input logic [data_bits-1:0] got,
                            input logic [data_bits-1:0] expected);
  if (got !== expected)
  begin
    word_errors++;
    $display("FAILED at %0t: dout is %h, expected %h", $time, got, expected);
  end
endtask

// full, empty and ready lights
task automatic compare_flags(input logic got_full, input logic got_empty,
                             input logic got_ready, input logic exp_full,
                             input logic exp_empty, input logic exp_ready);
  if ({got_full, got_empty, got_ready} !== {exp_full, exp_empty, exp_ready})
  begin
    flag_errors++;
    $display("FAILED at %0t: full/empty/ready are %b%b%b, expected %b%b%b", $time,
             got_full, got_empty, got_ready, exp_full, exp_empty, exp_ready);
  end
endtask

// occupancy, one bit wider than the address
task automatic compare_level(input logic [addr_bits:0] got,
                             input logic [addr_bits:0] expected);
  if (got !== expected)
  begin
    level_errors++;
    $display("FAILED at %0t: level is %0d, expected %0d", $time, got, expected);
  end
endtask

`endif

/* tb/tb_fifo_demo.sv */
`timescale 1ns/1ps

module tb_fifo_demo import fifo_demo_pkg::*;
();

  localparam int addr_bits    = default_addr_bits;
  localparam int data_bits    = default_data_bits;
  localparam int tick_divide  = default_tick_divide;
  localparam int repeat_ticks = default_repeat_ticks;
  localparam int depth        = 1 << addr_bits;
  localparam int level_bits   = addr_bits + 1;

  localparam int num_segments   = 300;
  localparam int directed_ticks = 40 + 10 + 40 + 4 + 4;  // fill, both held, drain, idle
  // every tick at most 12 per segment, plus reset and slack
  localparam int timeout_ns = (directed_ticks + num_segments * 12) * tick_divide * 20 + 4000;

  logic                 clock;
  logic                 reset;
  logic                 wr_button;
  logic                 rd_button;
  logic [data_bits-1:0] din;
  logic [data_bits-1:0] dout;
  logic                 full;
  logic                 empty;
  logic [addr_bits:0]   level;
  logic                 ready;

  integer seed = 49797;

  // reference model state
  logic [data_bits-1:0] model_q [$];         // words in write order
  logic [data_bits-1:0] model_dout = '0;
  logic                 model_ready = 1'b0;
  logic                 model_tick;
  logic                 model_wr_only;
  logic                 model_rd_only;
  fifo_op_t             model_op;
  int                   tick_count = 0;      // clocks since the last tick
  int                   wr_wait = 0;         // ticks until the next write repeat
  int                   rd_wait = 0;

  `include "tb_fifo_checks.svh"

  fifo_demo_top UUT (
    .clock     (clock),
    .reset     (reset),
    .wr_button (wr_button),
    .rd_button (rd_button),
    .din       (din),
    .dout      (dout),
    .full      (full),
    .empty     (empty),
    .level     (level),
    .ready     (ready)
  );

  always #10 clock = ~clock;  // 20 ns period

  // one segment of held buttons and switches, length in ticks
  task automatic hold_buttons(input logic wr, input logic rd,
                              input logic [data_bits-1:0] word, input int ticks);
    @(posedge clock);
    wr_button <= wr;
    rd_button <= rd;
    din       <= word;
    repeat (ticks * tick_divide - 1) @(posedge clock);
  endtask

  // model steps on the same edge, inputs read before they change
  always @(posedge clock)
  begin
    if (reset)
    begin
      model_q.delete();
      model_dout  = '0;
      model_ready = 1'b0;
      tick_count  = 0;
      wr_wait     = 0;
      rd_wait     = 0;
    end
    else
    begin
      model_ready   = 1'b1;
      model_tick    = (tick_count == tick_divide - 1);  // last clock of each period
      model_wr_only = wr_button && !rd_button;
      model_rd_only = rd_button && !wr_button;
      model_op      = op_none;
      if (model_tick)
      begin
        if (model_wr_only && wr_wait == 0)
          model_op = op_write;
        else if (model_rd_only && rd_wait == 0)
          model_op = op_read;
        // repeat counters, cleared when the button is not held alone
        if (!model_wr_only)
          wr_wait = 0;
        else if (wr_wait == 0)
          wr_wait = repeat_ticks - 1;
        else
          wr_wait--;
        if (!model_rd_only)
          rd_wait = 0;
        else if (rd_wait == 0)
          rd_wait = repeat_ticks - 1;
        else
          rd_wait--;
      end
      if (model_op == op_write && model_q.size() < depth)
        model_q.push_back(din);  // dropped when full
      if (model_op == op_read && model_q.size() > 0)
        model_dout = model_q.pop_front();  // empty read keeps dout
      tick_count = model_tick ? 0 : tick_count + 1;
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clock)
  begin
    compare_word(dout, model_dout);
    compare_flags(full, empty, ready, model_q.size() == depth, model_q.size() == 0,
                  model_ready);
    compare_level(level, level_bits'(model_q.size()));
  end

  initial
  begin
    #(timeout_ns);
    $display("timeout: stimulus did not finish within %0d ns", timeout_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    int                   state;
    int                   ticks;
    int                   total;
    logic [data_bits-1:0] word;
    clock     = 1'b0;
    reset     = 1'b1;
    wr_button = 1'b0;
    rd_button = 1'b0;
    din       = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    // every segment then opens in a tick cycle so a late sample of its inputs shows
    repeat (tick_divide - 2) @(posedge clock);
    // fill past full, a fresh word for each repeat
    for (int i = 0; i < 20; i++)
      hold_buttons(1'b1, 1'b0, data_bits'(i * 37 + 5), 2);
    hold_buttons(1'b1, 1'b1, 8'hc3, 10);  // both held, nothing moves
    hold_buttons(1'b0, 1'b1, 8'h00, 40);  // drain and keep reading empty
    hold_buttons(1'b0, 1'b0, 8'h00, 4);
    for (int seg = 0; seg < num_segments; seg++)
    begin
      state = {$random(seed)} % 4;  // none, write, read, both
      ticks = 1 + {$random(seed)} % 12;
      word  = data_bits'($random(seed));
      hold_buttons(state == 1 || state == 3, state == 2 || state == 3, word, ticks);
    end
    hold_buttons(1'b0, 1'b0, '0, 4);
    total = word_errors + flag_errors + level_errors;
    $display("errors: word %0d, flags %0d, level %0d", word_errors, flag_errors,
             level_errors);
    if (total == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* design/fifo_demo_top.sv */
`timescale 1ns/1ps

// push-button fifo demo
// switches give the word and two buttons push or pop
module fifo_demo_top import fifo_demo_pkg::*;
#(
  parameter int addr_bits    = default_addr_bits,
  parameter int data_bits    = default_data_bits,
  parameter int tick_divide  = default_tick_divide,
  parameter int repeat_ticks = default_repeat_ticks
)
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 wr_button,
  input  logic                 rd_button,
  input  logic [data_bits-1:0] din,     // switch bank
  output logic [data_bits-1:0] dout,
  output logic                 full,
  output logic                 empty,
  output logic [addr_bits:0]   level,
  output logic                 ready    // lit once out of reset
);

  logic                 tick;
  fifo_op_t             op;
  logic                 write_enable;
  logic [addr_bits-1:0] write_addr;
  logic                 read_enable;
  logic [addr_bits-1:0] read_addr;

  tick_divider #(.tick_divide(tick_divide)) u_tick_divider (
    .clock (clock),
    .reset (reset),
    .tick  (tick)
  );

  button_strober #(.repeat_ticks(repeat_ticks)) u_button_strober (
    .clock     (clock),
    .reset     (reset),
    .tick      (tick),
    .wr_button (wr_button),
    .rd_button (rd_button),
    .op        (op)
  );

  fifo_control #(.addr_bits(addr_bits)) u_fifo_control (
    .clock        (clock),
    .reset        (reset),
    .op           (op),
    .write_enable (write_enable),
    .write_addr   (write_addr),
    .read_enable  (read_enable),
    .read_addr    (read_addr),
    .full         (full),
    .empty        (empty),
    .level        (level)
  );

  fifo_storage #(.addr_bits(addr_bits), .data_bits(data_bits)) u_fifo_storage (
    .clock        (clock),
    .reset        (reset),
    .write_enable (write_enable),
    .write_addr   (write_addr),
    .din          (din),
    .read_enable  (read_enable),
    .read_addr    (read_addr),
    .dout         (dout)
  );

  // reset indicator light
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      ready <= 1'b0;
    else
      ready <= 1'b1;  // first edge after release
  end

endmodule

/* design/fifo_storage.sv */
`timescale 1ns/1ps

// word array with clocked write and registered read port
module fifo_storage import fifo_demo_pkg::*;
#(
  parameter int addr_bits = default_addr_bits,
  parameter int data_bits = default_data_bits
)
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 write_enable,
  input  logic [addr_bits-1:0] write_addr,
  input  logic [data_bits-1:0] din,
  input  logic                 read_enable,
  input  logic [addr_bits-1:0] read_addr,
  output logic [data_bits-1:0] dout
);

  logic [data_bits-1:0] mem [2**addr_bits];  // 2**addr_bits entries

  always_ff @(posedge clock)
  begin
    if (write_enable)
      mem[write_addr] <= din;  // switch word at the end of the write cycle
  end

  // dout keeps the last word popped
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      dout <= '0;
    else if (read_enable)
      dout <= mem[read_addr];
  end

endmodule

/* design/fifo_control.sv */
`timescale 1ns/1ps

// pointers, occupancy and flags of the fifo
// requests are gated here into storage enables
module fifo_control import fifo_demo_pkg::*;
#(
  parameter int addr_bits = default_addr_bits
)
(
  input  logic                 clock,
  input  logic                 reset,
  input  fifo_op_t             op,
  output logic                 write_enable,
  output logic [addr_bits-1:0] write_addr,
  output logic                 read_enable,
  output logic [addr_bits-1:0] read_addr,
  output logic                 full,
  output logic                 empty,
  output logic [addr_bits:0]   level
);

  // level one bit wider so a full fifo is distinct from an empty one
  localparam logic [addr_bits:0] depth = 1 << addr_bits;

  logic [addr_bits-1:0] wr_ptr;      // next slot to write
  logic [addr_bits-1:0] rd_ptr;      // next slot to read
  logic [addr_bits:0]   level_next;

  // blocked requests are simply dropped
  assign write_enable = (op == op_write) & ~full;
  assign read_enable  = (op == op_read) & ~empty;

  assign write_addr = wr_ptr;
  assign read_addr  = rd_ptr;

  // strober never issues both so only one direction at a time
  always_comb
  begin
    level_next = level;
    if (write_enable)
      level_next = level + 1'b1;
    else if (read_enable)
      level_next = level - 1'b1;
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end
    else
    begin
      if (write_enable)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at the top of the array
      if (read_enable)
        rd_ptr <= rd_ptr + 1'b1;
      level <= level_next;
      // flags follow the level they will sit beside
      full  <= (level_next == depth);
      empty <= (level_next == '0);
    end
  end

endmodule

/* design/button_strober.sv */
`timescale 1ns/1ps

// held buttons to single-cycle fifo requests
// one button alone fires at once and then every repeat_ticks ticks
module button_strober import fifo_demo_pkg::*;
#(
  parameter int repeat_ticks = default_repeat_ticks
)
(
  input  logic     clock,
  input  logic     reset,
  input  logic     tick,       // sampling enable
  input  logic     wr_button,
  input  logic     rd_button,
  output fifo_op_t op
);

  localparam int cnt_bits = (repeat_ticks > 1) ? $clog2(repeat_ticks) : 1;
  localparam logic [cnt_bits-1:0] reload = cnt_bits'(repeat_ticks - 1);

  logic [cnt_bits-1:0] wr_count;  // ticks left before the next write repeat
  logic [cnt_bits-1:0] rd_count;  // same for reads
  logic                wr_only;
  logic                rd_only;

  // both held counts as neither
  assign wr_only = wr_button & ~rd_button;
  assign rd_only = rd_button & ~wr_button;

  // request is decided in the tick cycle itself
  always_comb
  begin
    op = op_none;
    if (tick)
    begin
      if (wr_only && wr_count == '0)
        op = op_write;
      else if (rd_only && rd_count == '0)
        op = op_read;
    end
  end

  // repeat counters move only on ticks
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_count <= '0;
      rd_count <= '0;
    end
    else if (tick)
    begin
      if (wr_only)
        wr_count <= (wr_count == '0) ? reload : wr_count - 1'b1;  // fire then wait
      else
        wr_count <= '0;  // released or blocked by the other button
      if (rd_only)
        rd_count <= (rd_count == '0) ? reload : rd_count - 1'b1;
      else
        rd_count <= '0;
    end
  end

endmodule

/* design/tick_divider.sv */
`timescale 1ns/1ps

// one-clock enable pulse every tick_divide clocks
module tick_divider import fifo_demo_pkg::*;
#(
  parameter int tick_divide = default_tick_divide
)
(
  input  logic clock,
  input  logic reset,
  output logic tick
);

  // counter needs at least one bit even for tick_divide of 1
  localparam int cnt_bits = (tick_divide > 1) ? $clog2(tick_divide) : 1;
  localparam logic [cnt_bits-1:0] last_count = cnt_bits'(tick_divide - 1);

  logic [cnt_bits-1:0] count;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      count <= '0;
    else if (count == last_count)
      count <= '0;  // wrap for the next period
    else
      count <= count + 1'b1;
  end

  // high during the final count of each period
  assign tick = (count == last_count);

endmodule

/* design/fifo_demo_pkg.sv */
package fifo_demo_pkg;

  // one request to the fifo as issued by the strober
  // at most one of write or read per clock
  typedef enum logic [1:0] {
    op_none  = 2'd0,  // idle, also every non-tick cycle
    op_write = 2'd1,  // push the switch word
    op_read  = 2'd2   // pop into dout
  } fifo_op_t;

  // address width gives 2**addr_bits entries
  localparam int default_addr_bits = 4;

  // width of a stored word, matches the switch bank
  localparam int default_data_bits = 8;

  // clocks per tick
  // small for simulation, a board build would set this in the millions
  localparam int default_tick_divide = 4;

  // ticks between repeats while one button stays down
  localparam int default_repeat_ticks = 2;

endpackage
